// File: src/merge_data_pkg.sv
// Merge datapath definitions
// Element width, array size limits and the index types for A, B, C and M
`default_nettype none

package merge_data_pkg;

	// Element width
	localparam int DATA_W = 8;

	// Supported entries per input array
	localparam int MAX_DEPTH = 15;
	localparam int DEPTH_DEF = 4;

	// Index widths, an input index must also hold DEPTH itself
	localparam int IN_IDX_W  = $clog2(MAX_DEPTH + 1);
	localparam int OUT_IDX_W = $clog2(3 * MAX_DEPTH);

	typedef logic [DATA_W-1:0] data_t;

	// Index into A, B or C, the value DEPTH marks an exhausted source
	typedef logic [IN_IDX_W-1:0] in_idx_t;

	// Index into the merged array M
	typedef logic [OUT_IDX_W-1:0] out_idx_t;

endpackage

`default_nettype wire

// File: src/merge_ctrl_pkg.sv
// Merge control definitions
// State encoding, source select and live-source vector layout
`default_nettype none

package merge_ctrl_pkg;

	// Merge states are named after the sources still live
	typedef enum logic [3:0] {
		S_IDLE,
		S_ABC,
		S_AB,
		S_AC,
		S_BC,
		S_A,
		S_B,
		S_C,
		S_DONE
	} merge_state_t;

	// Source whose head goes to M this cycle
	typedef enum logic [1:0] {
		SRC_A,
		SRC_B,
		SRC_C
	} src_t;

	// Bit positions in the live vector
	localparam int LIVE_A = 2;
	localparam int LIVE_B = 1;
	localparam int LIVE_C = 0;

endpackage

`default_nettype wire

// File: src/merge_pick.sv
// Head selection for the three-way merge
// Picks the smallest head among the live sources, ties go A, then B, then C
`timescale 1ns/1ns
`default_nettype none

module merge_pick
(
	input  wire logic [2:0]            live,
	input  wire merge_data_pkg::data_t a_head,
	input  wire merge_data_pkg::data_t b_head,
	input  wire merge_data_pkg::data_t c_head,
	output merge_ctrl_pkg::src_t       sel
);

	import merge_ctrl_pkg::*;

	logic a_live;
	logic b_live;
	logic c_live;
	logic a_wins;
	logic b_wins;

	assign a_live = live[LIVE_A];
	assign b_live = live[LIVE_B];
	assign c_live = live[LIVE_C];

	// ----------------------------------------
	// Comparisons
	// ----------------------------------------
	// A dead source drops out of the compare before its head is looked at,
	// so the X read from an exhausted memory never reaches sel

	// A wins on equality against both others
	assign a_wins = a_live &&
		(!b_live || (a_head <= b_head)) &&
		(!c_live || (a_head <= c_head));

	// B must beat A strictly, but wins a tie with C
	assign b_wins = b_live &&
		(!a_live || (b_head < a_head)) &&
		(!c_live || (b_head <= c_head));

	always_comb
	begin
		if (a_wins)
			sel = SRC_A;
		else if (b_wins)
			sel = SRC_B;
		else
			// C, also the idle default when nothing is live
			sel = SRC_C;
	end

endmodule

`default_nettype wire

// File: src/merge_pointers.sv
// Read and write indexes of the merge engine
// Steps the selected source index and the M address, flags a source's last element
`timescale 1ns/1ns
`default_nettype none

module merge_pointers
#(
	parameter int DEPTH = merge_data_pkg::DEPTH_DEF
)
(
	input  wire logic                   Clk,
	input  wire logic                   rst_n,
	input  wire logic                   clear,
	input  wire logic                   advance,
	input  wire merge_ctrl_pkg::src_t   sel,
	output merge_data_pkg::in_idx_t     a_idx,
	output merge_data_pkg::in_idx_t     b_idx,
	output merge_data_pkg::in_idx_t     c_idx,
	output merge_data_pkg::out_idx_t    m_addr,
	output logic                        a_last,
	output logic                        b_last,
	output logic                        c_last
);

	import merge_data_pkg::*;
	import merge_ctrl_pkg::*;

	// Index of the final element in each input array
	localparam in_idx_t LAST_IDX = in_idx_t'(DEPTH - 1);

	// ----------------------------------------
	// Index registers
	// ----------------------------------------
	always_ff @(posedge Clk)
	begin
		if (!rst_n || clear)
		begin
			a_idx  <= '0;
			b_idx  <= '0;
			c_idx  <= '0;
			m_addr <= '0;
		end
		else if (advance)
		begin
			// Only the source just written moves on
			case (sel)
				SRC_A:   a_idx <= a_idx + 1'b1;
				SRC_B:   b_idx <= b_idx + 1'b1;
				default: c_idx <= c_idx + 1'b1;
			endcase
			m_addr <= m_addr + 1'b1;
		end
	end

	// ----------------------------------------
	// Last-element flags
	// ----------------------------------------
	// Only the selected source can raise its flag
	assign a_last = (sel == SRC_A) && (a_idx == LAST_IDX);
	assign b_last = (sel == SRC_B) && (b_idx == LAST_IDX);
	assign c_last = (sel == SRC_C) && (c_idx == LAST_IDX);

endmodule

`default_nettype wire

// File: src/merge_fsm.sv
// Merge control state machine
// Start and acknowledge handshake, live-source tracking and write enable
`timescale 1ns/1ns
`default_nettype none

module merge_fsm
(
	input  wire logic                 Clk,
	input  wire logic                 rst_n,
	input  wire logic                 start,
	input  wire logic                 ack,
	input  wire merge_ctrl_pkg::src_t sel,
	input  wire logic                 a_last,
	input  wire logic                 b_last,
	input  wire logic                 c_last,
	output logic [2:0]                live,
	output logic                      clear,
	output logic                      advance,
	output logic                      m_write,
	output logic                      done
);

	import merge_ctrl_pkg::*;

	merge_state_t state;
	merge_state_t state_nxt;
	logic         sel_last;
	logic         merging;

	// Last flag of the source written this cycle
	always_comb
	begin
		case (sel)
			SRC_A:   sel_last = a_last;
			SRC_B:   sel_last = b_last;
			default: sel_last = c_last;
		endcase
	end

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:
				if (start)
					state_nxt = S_ABC;
			// Drop the source that just gave up its last element
			S_ABC:
				if (sel_last)
				begin
					case (sel)
						SRC_A:   state_nxt = S_BC;
						SRC_B:   state_nxt = S_AC;
						default: state_nxt = S_AB;
					endcase
				end
			S_AB:
				if (sel_last)
					state_nxt = (sel == SRC_A) ? S_B : S_A;
			S_AC:
				if (sel_last)
					state_nxt = (sel == SRC_A) ? S_C : S_A;
			S_BC:
				if (sel_last)
					state_nxt = (sel == SRC_B) ? S_C : S_B;
			S_A, S_B, S_C:
				if (sel_last)
					state_nxt = S_DONE;
			S_DONE:
				if (ack)
					state_nxt = S_IDLE;
			default:
				state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------
	// Live set, bit order A B C
	always_comb
	begin
		case (state)
			S_ABC:   live = 3'b111;
			S_AB:    live = 3'b110;
			S_AC:    live = 3'b101;
			S_BC:    live = 3'b011;
			S_A:     live = 3'b100;
			S_B:     live = 3'b010;
			S_C:     live = 3'b001;
			default: live = 3'b000;
		endcase
	end

	assign merging = (state != S_IDLE) && (state != S_DONE);

	// One element written per merge cycle
	assign m_write = merging;
	assign advance = merging;

	assign clear = (state == S_IDLE) && start;
	assign done  = (state == S_DONE);

endmodule

`default_nettype wire

// File: src/merge_sort_top.sv
// Three-way merge engine top level
// Merges presorted arrays A, B and C into M, one element per clock
`timescale 1ns/1ns
`default_nettype none

module merge_sort_top
#(
	parameter int DEPTH = merge_data_pkg::DEPTH_DEF
)
(
	input  wire logic                     Clk,
	input  wire logic                     rst_n,
	input  wire logic                     start,
	input  wire logic                     ack,
	output merge_data_pkg::in_idx_t       a_idx,
	output merge_data_pkg::in_idx_t       b_idx,
	output merge_data_pkg::in_idx_t       c_idx,
	input  wire merge_data_pkg::data_t    a_data,
	input  wire merge_data_pkg::data_t    b_data,
	input  wire merge_data_pkg::data_t    c_data,
	output logic                          m_write,
	output merge_data_pkg::out_idx_t      m_addr,
	output merge_data_pkg::data_t         m_data,
	output logic                          done
);

	import merge_ctrl_pkg::*;

	logic [2:0] live;
	src_t       sel;
	logic       clear;
	logic       advance;
	logic       a_last;
	logic       b_last;
	logic       c_last;

	// ----------------------------------------
	// Datapath
	// ----------------------------------------
	merge_pick u_merge_pick (
		.live   (live),
		.a_head (a_data),
		.b_head (b_data),
		.c_head (c_data),
		.sel    (sel)
	);

	merge_pointers #(
		.DEPTH (DEPTH)
	) u_merge_pointers (
		.Clk     (Clk),
		.rst_n   (rst_n),
		.clear   (clear),
		.advance (advance),
		.sel     (sel),
		.a_idx   (a_idx),
		.b_idx   (b_idx),
		.c_idx   (c_idx),
		.m_addr  (m_addr),
		.a_last  (a_last),
		.b_last  (b_last),
		.c_last  (c_last)
	);

	// Winning head goes straight to M
	always_comb
	begin
		case (sel)
			SRC_A:   m_data = a_data;
			SRC_B:   m_data = b_data;
			default: m_data = c_data;
		endcase
	end

	// ----------------------------------------
	// Control
	// ----------------------------------------
	merge_fsm u_merge_fsm (
		.Clk     (Clk),
		.rst_n   (rst_n),
		.start   (start),
		.ack     (ack),
		.sel     (sel),
		.a_last  (a_last),
		.b_last  (b_last),
		.c_last  (c_last),
		.live    (live),
		.clear   (clear),
		.advance (advance),
		.m_write (m_write),
		.done    (done)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
// Testbench clock source
// Free-running clock with a configurable period
`timescale 1ns/1ns
`default_nettype none

module tb_clock
#(
	parameter int PERIOD = 8
)
(
	output logic Clk
);

	initial
	begin
		Clk = 1'b0;
	end

	always #(PERIOD / 2) Clk = ~Clk;

endmodule

`default_nettype wire

// File: sim/merge_sort_tb.sv
// Testbench for the three-way merge engine
// Reads tests from merge_testdata.txt, models memories A, B, C and M, checks results
`timescale 1ns/1ns
`default_nettype none

module merge_sort_tb;

	import merge_data_pkg::*;

	localparam int D         = DEPTH_DEF;
	localparam int N_OUT     = 3 * D;
	localparam int MAX_TESTS = 64;

	logic     Clk;
	logic     rst_n;
	logic     start;
	logic     ack;
	in_idx_t  a_idx;
	in_idx_t  b_idx;
	in_idx_t  c_idx;
	data_t    a_data;
	data_t    b_data;
	data_t    c_data;
	logic     m_write;
	out_idx_t m_addr;
	data_t    m_data;
	logic     done;

	// Memory models
	data_t mem_a [0:D-1];
	data_t mem_b [0:D-1];
	data_t mem_c [0:D-1];
	data_t mem_m [0:3*MAX_DEPTH-1];

	// Test vectors
	logic [8*24-1:0] tv_name [0:MAX_TESTS-1];
	data_t           tv_in   [0:MAX_TESTS-1][0:N_OUT-1];
	data_t           tv_exp  [0:MAX_TESTS-1][0:N_OUT-1];
	int              n_tests;

	int mismatch_errors;
	int other_errors;

	// High from the start edge until done is seen
	logic busy;

	tb_clock #(
		.PERIOD (8)
	) u_tb_clock (
		.Clk (Clk)
	);

	merge_sort_top #(
		.DEPTH (D)
	) u_merge_sort_top (
		.Clk     (Clk),
		.rst_n   (rst_n),
		.start   (start),
		.ack     (ack),
		.a_idx   (a_idx),
		.b_idx   (b_idx),
		.c_idx   (c_idx),
		.a_data  (a_data),
		.b_data  (b_data),
		.c_data  (c_data),
		.m_write (m_write),
		.m_addr  (m_addr),
		.m_data  (m_data),
		.done    (done)
	);

	// Same-cycle reads that return X past the end of an array
	assign a_data = (a_idx < D) ? mem_a[a_idx] : 'x;
	assign b_data = (b_idx < D) ? mem_b[b_idx] : 'x;
	assign c_data = (c_idx < D) ? mem_c[c_idx] : 'x;

	always @(posedge Clk)
	begin
		if (m_write)
			mem_m[m_addr] <= m_data;
	end

	// No writes outside a merge
	always @(negedge Clk)
	begin
		if (rst_n && !busy && m_write)
		begin
			other_errors++;
			$display("write while idle at time %0t", $time);
		end
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_data(input string test, input string what, input data_t exp,
		input data_t act);
		if (act !== exp)
		begin
			mismatch_errors++;
			$display("mismatch %0s %0s: expected %h, actual %h", test, what, exp, act);
		end
	endtask

	task automatic check_addr(input string test, input string what, input out_idx_t exp,
		input out_idx_t act);
		if (act !== exp)
		begin
			mismatch_errors++;
			$display("mismatch %0s %0s: expected %0d, actual %0d", test, what, exp, act);
		end
	endtask

	task automatic check_count(input string test, input string what, input int exp,
		input int act);
		if (act != exp)
		begin
			mismatch_errors++;
			$display("mismatch %0s %0s: expected %0d, actual %0d", test, what, exp, act);
		end
	endtask

	// ----------------------------------------
	// Test file
	// ----------------------------------------
	task automatic read_tests();
		int    fd;
		int    rc;
		string line;
		fd = $fopen("sim/merge_testdata.txt", "r");
		if (fd == 0)
		begin
			other_errors++;
			$display("cannot open sim/merge_testdata.txt");
			return;
		end
		while (!$feof(fd) && n_tests < MAX_TESTS)
		begin
			line = "";
			rc = $fgets(line, fd);
			if (rc != 0 && line.len() > 1 && line.getc(0) != "#")
			begin
				rc = $sscanf(line,
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					tv_name[n_tests],
					tv_in[n_tests][0], tv_in[n_tests][1], tv_in[n_tests][2],
					tv_in[n_tests][3], tv_in[n_tests][4], tv_in[n_tests][5],
					tv_in[n_tests][6], tv_in[n_tests][7], tv_in[n_tests][8],
					tv_in[n_tests][9], tv_in[n_tests][10], tv_in[n_tests][11],
					tv_exp[n_tests][0], tv_exp[n_tests][1], tv_exp[n_tests][2],
					tv_exp[n_tests][3], tv_exp[n_tests][4], tv_exp[n_tests][5],
					tv_exp[n_tests][6], tv_exp[n_tests][7], tv_exp[n_tests][8],
					tv_exp[n_tests][9], tv_exp[n_tests][10], tv_exp[n_tests][11]);
				if (rc == 25)
					n_tests++;
				else
				begin
					other_errors++;
					$display("malformed line in test file: %0s", line);
				end
			end
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// One merge with handshake
	// ----------------------------------------
	task automatic run_test(input int t);
		string name;
		int    k;
		int    writes;
		bit    seen_done;
		name = string'(tv_name[t]);
		for (int i = 0; i < D; i++)
		begin
			mem_a[i] = tv_in[t][i];
			mem_b[i] = tv_in[t][D + i];
			mem_c[i] = tv_in[t][2 * D + i];
		end
		for (int i = 0; i < 3 * MAX_DEPTH; i++)
			mem_m[i] = 'x;

		@(posedge Clk);
		start <= 1'b1;
		// This edge samples start
		@(posedge Clk);
		start <= 1'b0;
		busy = 1'b1;

		writes = 0;
		seen_done = 1'b0;
		k = 0;
		while (!seen_done && k < N_OUT + 20)
		begin
			@(negedge Clk);
			k++;
			if (m_write)
			begin
				// Writes must fill the cycles right after start, back to back
				check_count(name, "write cycle", writes + 1, k);
				check_addr(name, "m_addr", out_idx_t'(writes), m_addr);
				if ($isunknown(m_data))
				begin
					other_errors++;
					$display("%0s: m_data is unknown on write %0d", name, writes);
				end
				writes++;
			end
			if (done)
				seen_done = 1'b1;
		end
		busy = 1'b0;
		if (!seen_done)
		begin
			other_errors++;
			$display("%0s: done never rose", name);
			return;
		end

		// Edge that first samples done high
		check_count(name, "latency", N_OUT + 1, k);
		check_count(name, "write count", N_OUT, writes);
		for (int i = 0; i < N_OUT; i++)
			check_data(name, $sformatf("M[%0d]", i), tv_exp[t][i], mem_m[i]);

		// Hold ack low, with a stray start pulse in the middle
		for (int i = 0; i < 5; i++)
		begin
			@(posedge Clk);
			start <= (i == 1);
			@(negedge Clk);
			check_count(name, "done held", 1, int'(done));
		end
		@(posedge Clk);
		start <= 1'b0;
		ack   <= 1'b1;
		@(posedge Clk);
		ack <= 1'b0;
		@(negedge Clk);
		check_count(name, "done after ack", 0, int'(done));
	endtask

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------
	initial
	begin
		wait (n_tests > 0);
		#((n_tests + 1) * (N_OUT + 20) * 8);
		$display("timeout after %0d tests worth of cycles", n_tests);
		$display("Test FAILED");
		$finish;
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		rst_n           = 1'b0;
		start           = 1'b0;
		ack             = 1'b0;
		busy            = 1'b0;
		n_tests         = 0;
		mismatch_errors = 0;
		other_errors    = 0;

		read_tests();
		if (n_tests == 0)
		begin
			other_errors++;
			$display("no tests found in the test file");
		end

		repeat (8) @(posedge Clk);
		rst_n <= 1'b1;
		@(negedge Clk);
		check_count("reset", "done", 0, int'(done));
		check_count("reset", "m_write", 0, int'(m_write));

		for (int t = 0; t < n_tests; t++)
			run_test(t);

		repeat (2) @(posedge Clk);
		$display("%0d tests, %0d mismatch errors, %0d other errors",
			n_tests, mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/merge_testdata.txt
# name, A0-A3, B0-B3, C0-C3, then the 12 expected M values, all in hex
# Each array is ascending, ties in M resolve to equal values
disjoint_abc 01 02 03 04 10 11 12 13 20 21 22 23 01 02 03 04 10 11 12 13 20 21 22 23
disjoint_acb 01 02 03 04 20 21 22 23 10 11 12 13 01 02 03 04 10 11 12 13 20 21 22 23
disjoint_bac 10 11 12 13 01 02 03 04 20 21 22 23 01 02 03 04 10 11 12 13 20 21 22 23
disjoint_bca 20 21 22 23 01 02 03 04 10 11 12 13 01 02 03 04 10 11 12 13 20 21 22 23
disjoint_cab 10 11 12 13 20 21 22 23 01 02 03 04 01 02 03 04 10 11 12 13 20 21 22 23
disjoint_cba 20 21 22 23 10 11 12 13 01 02 03 04 01 02 03 04 10 11 12 13 20 21 22 23
all_equal 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55 55
a_zeros 00 00 00 00 05 06 07 08 01 02 03 09 00 00 00 00 01 02 03 05 06 07 08 09
b_zeros 03 07 0b 0f 00 00 00 00 02 04 06 08 00 00 00 00 02 03 04 06 07 08 0b 0f
c_zeros 11 22 33 44 10 20 30 40 00 00 00 00 00 00 00 00 10 11 20 22 30 33 40 44
interleave 00 03 06 09 01 04 07 0a 02 05 08 0b 00 01 02 03 04 05 06 07 08 09 0a 0b
max_values fd fe ff ff ff ff ff ff fc fd fe ff fc fd fd fe fe ff ff ff ff ff ff ff
ties_ab 10 20 30 40 10 20 30 40 50 60 70 80 10 10 20 20 30 30 40 40 50 60 70 80
ties_bc 90 a0 b0 c0 05 15 25 35 05 15 25 35 05 05 15 15 25 25 35 35 90 a0 b0 c0
ties_ac 01 01 02 02 80 81 82 83 01 02 02 03 01 01 01 02 02 02 02 03 80 81 82 83
one_large 00 01 02 ff 03 04 05 06 07 08 09 0a 00 01 02 03 04 05 06 07 08 09 0a ff
mixed 0a 14 1e 28 05 19 2d 41 0f 23 37 4b 05 0a 0f 14 19 1e 23 28 2d 37 41 4b
spread 00 40 80 c0 20 60 a0 e0 10 30 50 70 00 10 20 30 40 50 60 70 80 a0 c0 e0
c_tail 01 05 09 0d 02 06 0a 0e 03 04 f0 f1 01 02 03 04 05 06 09 0a 0d 0e f0 f1
dup_runs 07 07 07 08 06 07 08 08 07 08 08 09 06 07 07 07 07 07 08 08 08 08 08 09

// File: list.f
src/merge_data_pkg.sv
src/merge_ctrl_pkg.sv
src/merge_pick.sv
src/merge_pointers.sv
src/merge_fsm.sv
src/merge_sort_top.sv
sim/tb_clock.sv
sim/merge_sort_tb.sv
